// ==== verilog/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

	localparam int addr_w = 16;	// processor byte address
	localparam int word_w = 32;
	localparam int words_per_line = 4;
	localparam int line_w = word_w * words_per_line;	// one memory transfer
	localparam int sets = 16;
	localparam int index_w = 4;
	localparam int word_sel_w = 2;	// word within a line
	localparam int offset_w = 2;	// byte within a word
	localparam int tag_w = addr_w - index_w - word_sel_w - offset_w;
	localparam int line_addr_w = tag_w + index_w;	// memory side address

	// processor address seen either as a plain word or split into fields
	typedef union packed {
		logic [addr_w-1:0] raw;
		struct packed {
			logic [tag_w-1:0] tag;
			logic [index_w-1:0] index;
			logic [word_sel_w-1:0] word;
			logic [offset_w-1:0] offset;	// zero for aligned access
		} fields;
	} cache_addr_t;

	typedef enum logic [2:0] {
		idle,	// waiting for a setup phase
		lookup,	// access phase, tag compare
		write_back,	// dirty victim to memory
		refill,	// line fetch
		respond	// finish a missed access
	} ctrl_state_t;

endpackage

`default_nettype wire

// ==== verilog/cache_way.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_way import cache_pkg::*; (
	input wire clk,
	input wire reset,
	input wire [index_w-1:0] index,
	input wire [tag_w-1:0] tag,
	input wire [word_sel_w-1:0] word,
	input wire word_we,
	input wire [word_w-1:0] word_wdata,
	input wire fill_en,
	input wire [line_w-1:0] fill_line,
	input wire [tag_w-1:0] fill_tag,
	input wire dirty_set,
	output logic hit,
	output logic [word_w-1:0] rdata,
	output logic [line_w-1:0] line,
	output logic [tag_w-1:0] line_tag,
	output logic dirty
);

	logic [tag_w-1:0] tag_mem [sets];
	logic [words_per_line-1:0][word_w-1:0] data_mem [sets];
	logic [sets-1:0] valid_bits;
	logic [sets-1:0] dirty_bits;

	// lookup works on the registered contents of the indexed set
	assign hit = valid_bits[index] && (tag_mem[index] == tag);
	assign rdata = data_mem[index][word];
	assign line = data_mem[index];	// write-back source
	assign line_tag = tag_mem[index];
	assign dirty = dirty_bits[index];

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (fill_en) begin
			valid_bits[index] <= 1'b1;
			dirty_bits[index] <= dirty_set;	// set when the fill carries a write
		end else if (word_we) begin
			dirty_bits[index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_en) begin
			tag_mem[index] <= fill_tag;
			data_mem[index] <= fill_line;	// whole line
		end else if (word_we) begin
			data_mem[index][word] <= word_wdata;	// one word only
		end
	end

	// the controller writes a way on a hit or on a refill and never both at once
	a_fill_or_write: assert property (
		@(posedge clk) disable iff (reset)
		!(fill_en && word_we)
	) else $error("cache_way: fill and word write in the same cycle");

endmodule

`default_nettype wire

// ==== verilog/cache_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_ctrl import cache_pkg::*; (
	input wire clk,
	input wire reset,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [addr_w-1:0] paddr,
	input wire [word_w-1:0] pwdata,
	output logic [word_w-1:0] prdata,
	output logic pready,
	input wire hit0,
	input wire hit1,
	input wire [word_w-1:0] rdata0,
	input wire [word_w-1:0] rdata1,
	input wire [line_w-1:0] line0,
	input wire [line_w-1:0] line1,
	input wire [tag_w-1:0] tag0,
	input wire [tag_w-1:0] tag1,
	input wire dirty0,
	input wire dirty1,
	output logic [index_w-1:0] index,
	output logic [tag_w-1:0] tag,
	output logic [word_sel_w-1:0] word,
	output logic we0,
	output logic we1,
	output logic fill0,
	output logic fill1,
	output logic [word_w-1:0] wdata,
	output logic [line_w-1:0] fill_line,
	input wire [line_w-1:0] mem_prdata,
	input wire mem_pready,
	output logic mem_psel,
	output logic mem_penable,
	output logic mem_pwrite,
	output logic [line_addr_w-1:0] mem_paddr,
	output logic [line_w-1:0] mem_pwdata
);

	cache_addr_t req;
	ctrl_state_t state;
	logic [sets-1:0] lru;	// way to replace next, per set
	logic victim;	// way chosen on the current miss
	logic hit;
	logic victim_dirty;
	logic mem_done;
	logic [tag_w-1:0] victim_tag;

	assign req.raw = paddr;	// requester holds paddr for the whole access
	assign index = req.fields.index;
	assign tag = req.fields.tag;
	assign word = req.fields.word;

	assign hit = hit0 || hit1;
	assign prdata = hit1 ? rdata1 : rdata0;
	assign victim_dirty = lru[index] ? dirty1 : dirty0;	// checked before victim is latched
	assign mem_done = mem_psel && mem_penable && mem_pready;

	// hits answer in the access phase and misses from respond
	assign pready = ((state == lookup) && hit) || (state == respond);

	assign wdata = pwdata;
	assign we0 = (state == lookup) && pwrite && hit0;
	assign we1 = (state == lookup) && pwrite && hit1;
	assign fill0 = (state == refill) && mem_done && !victim;
	assign fill1 = (state == refill) && mem_done && victim;

	// a missed write is merged into the incoming line
	always_comb begin
		fill_line = mem_prdata;
		if (pwrite) begin
			fill_line[word*word_w +: word_w] = pwdata;
		end
	end

	assign victim_tag = victim ? tag1 : tag0;
	assign mem_pwrite = (state == write_back);
	assign mem_paddr = mem_pwrite ? {victim_tag, index} : {tag, index};
	assign mem_pwdata = victim ? line1 : line0;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			lru <= '0;
			victim <= 1'b0;
			mem_psel <= 1'b0;
			mem_penable <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (psel && !penable) begin	// setup phase seen
						state <= lookup;
					end
				end
				lookup: begin
					if (hit) begin
						lru[index] <= hit0;	// other way becomes the victim
						state <= idle;
					end else begin
						victim <= lru[index];
						mem_psel <= 1'b1;	// setup of the first memory transfer
						mem_penable <= 1'b0;
						state <= victim_dirty ? write_back : refill;
					end
				end
				write_back: begin
					if (!mem_penable) begin
						mem_penable <= 1'b1;
					end else if (mem_pready) begin
						mem_penable <= 1'b0;	// psel stays up for the back to back read
						state <= refill;
					end
				end
				refill: begin
					if (!mem_penable) begin
						mem_penable <= 1'b1;
					end else if (mem_pready) begin
						mem_psel <= 1'b0;
						mem_penable <= 1'b0;
						lru[index] <= !victim;	// fresh line is most recent
						state <= respond;
					end
				end
				respond: begin
					state <= idle;	// filled way now hits
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// a tag lives in at most one way of a set
	a_single_hit: assert property (
		@(posedge clk) disable iff (reset)
		!(hit0 && hit1)
	) else $error("cache_ctrl: both ways hit");

	a_mem_enable: assert property (
		@(posedge clk) disable iff (reset)
		mem_penable |-> mem_psel
	) else $error("cache_ctrl: mem_penable without mem_psel");

	a_aligned: assert property (
		@(posedge clk) disable iff (reset)
		psel |-> (req.fields.offset == '0)
	) else $error("cache_ctrl: unaligned paddr");

endmodule

`default_nettype wire

// ==== verilog/cache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_top import cache_pkg::*; (
	input wire clk,
	input wire reset,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [addr_w-1:0] paddr,
	input wire [word_w-1:0] pwdata,
	output logic [word_w-1:0] prdata,
	output logic pready,
	output logic mem_psel,
	output logic mem_penable,
	output logic mem_pwrite,
	output logic [line_addr_w-1:0] mem_paddr,
	output logic [line_w-1:0] mem_pwdata,
	input wire [line_w-1:0] mem_prdata,
	input wire mem_pready
);

	logic [index_w-1:0] index;
	logic [tag_w-1:0] tag;
	logic [word_sel_w-1:0] word;
	logic we0;
	logic we1;
	logic fill0;
	logic fill1;
	logic [word_w-1:0] wdata;
	logic [line_w-1:0] fill_line;
	logic hit0;
	logic hit1;
	logic [word_w-1:0] rdata0;
	logic [word_w-1:0] rdata1;
	logic [line_w-1:0] line0;
	logic [line_w-1:0] line1;
	logic [tag_w-1:0] tag0;
	logic [tag_w-1:0] tag1;
	logic dirty0;
	logic dirty1;

	// a refill that carries a write leaves the line dirty
	cache_way way0 (
		.clk(clk),
		.reset(reset),
		.index(index),
		.tag(tag),
		.word(word),
		.word_we(we0),
		.word_wdata(wdata),
		.fill_en(fill0),
		.fill_line(fill_line),
		.fill_tag(tag),
		.dirty_set(pwrite),
		.hit(hit0),
		.rdata(rdata0),
		.line(line0),
		.line_tag(tag0),
		.dirty(dirty0)
	);

	cache_way way1 (
		.clk(clk),
		.reset(reset),
		.index(index),
		.tag(tag),
		.word(word),
		.word_we(we1),
		.word_wdata(wdata),
		.fill_en(fill1),
		.fill_line(fill_line),
		.fill_tag(tag),
		.dirty_set(pwrite),
		.hit(hit1),
		.rdata(rdata1),
		.line(line1),
		.line_tag(tag1),
		.dirty(dirty1)
	);

	cache_ctrl ctrl0 (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.hit0(hit0),
		.hit1(hit1),
		.rdata0(rdata0),
		.rdata1(rdata1),
		.line0(line0),
		.line1(line1),
		.tag0(tag0),
		.tag1(tag1),
		.dirty0(dirty0),
		.dirty1(dirty1),
		.index(index),
		.tag(tag),
		.word(word),
		.we0(we0),
		.we1(we1),
		.fill0(fill0),
		.fill1(fill1),
		.wdata(wdata),
		.fill_line(fill_line),
		.mem_prdata(mem_prdata),
		.mem_pready(mem_pready),
		.mem_psel(mem_psel),
		.mem_penable(mem_penable),
		.mem_pwrite(mem_pwrite),
		.mem_paddr(mem_paddr),
		.mem_pwdata(mem_pwdata)
	);

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #2 clk = ~clk;	// 4 ns period

endmodule

`default_nettype wire

// ==== verification/mem_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_model import cache_pkg::*; (
	input wire clk,
	input wire mem_psel,
	input wire mem_penable,
	input wire mem_pwrite,
	input wire [line_addr_w-1:0] mem_paddr,
	input wire [line_w-1:0] mem_pwdata,
	output logic [line_w-1:0] mem_prdata,
	output logic mem_pready
);

	logic [line_w-1:0] lines [1 << line_addr_w];
	int wait_left;	// stall cycles still to insert
	int xfer_count;	// transfers granted so far
	int rd_count;
	int wr_count;
	int last_rd_num;	// position of the latest read in the transfer order
	int last_wr_num;
	logic [line_addr_w-1:0] last_rd_addr;
	logic [line_addr_w-1:0] last_wr_addr;
	logic [line_w-1:0] last_wr_data;

	// every word holds a value made from its own byte address
	function automatic logic [word_w-1:0] pattern_word(input int unsigned line_addr,
			input int unsigned word_sel);
		logic [addr_w-1:0] byte_addr;
		byte_addr = {line_addr[line_addr_w-1:0], word_sel[word_sel_w-1:0], 2'b00};
		return {byte_addr ^ 16'h5ca1, byte_addr};
	endfunction

	initial begin
		mem_prdata = '0;
		mem_pready = 1'b0;
		wait_left = 0;
		xfer_count = 0;
		rd_count = 0;
		wr_count = 0;
		last_rd_num = 0;
		last_wr_num = 0;
		last_rd_addr = '0;
		last_wr_addr = '0;
		last_wr_data = '0;
		for (int l = 0; l < (1 << line_addr_w); l++) begin
			for (int w = 0; w < words_per_line; w++) begin
				lines[l][w*word_w +: word_w] = pattern_word(l, w);
			end
		end
	end

	always @(negedge clk) begin
		if (mem_psel && !mem_penable) begin
			wait_left = $urandom % 4;	// 0 to 3 stalls for this transfer
			mem_pready <= 1'b0;
		end else if (mem_psel && mem_penable && !mem_pready) begin
			if (wait_left > 0) begin
				wait_left--;
			end else begin
				xfer_count++;
				mem_pready <= 1'b1;	// transfer ends at the next rising edge
				if (mem_pwrite) begin
					lines[mem_paddr] = mem_pwdata;
					wr_count++;
					last_wr_num = xfer_count;
					last_wr_addr = mem_paddr;
					last_wr_data = mem_pwdata;
				end else begin
					mem_prdata <= lines[mem_paddr];
					rd_count++;
					last_rd_num = xfer_count;
					last_rd_addr = mem_paddr;
				end
			end
		end else begin
			mem_pready <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== verification/cache_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_tb import cache_pkg::*; ();

	localparam int access_limit = 200;	// cycles allowed for one processor access

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [addr_w-1:0] paddr;
	logic [word_w-1:0] pwdata;
	logic [word_w-1:0] prdata;
	logic pready;
	logic mem_psel;
	logic mem_penable;
	logic mem_pwrite;
	logic [line_addr_w-1:0] mem_paddr;
	logic [line_w-1:0] mem_pwdata;
	logic [line_w-1:0] mem_prdata;
	logic mem_pready;
	logic [word_w-1:0] ref_mem [1 << (addr_w - 2)];	// what a memory without cache holds

	tb_clock clk0 (
		.clk(clk)
	);

	cache_top dut0 (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.mem_psel(mem_psel),
		.mem_penable(mem_penable),
		.mem_pwrite(mem_pwrite),
		.mem_paddr(mem_paddr),
		.mem_pwdata(mem_pwdata),
		.mem_prdata(mem_prdata),
		.mem_pready(mem_pready)
	);

	mem_model mem0 (
		.clk(clk),
		.mem_psel(mem_psel),
		.mem_penable(mem_penable),
		.mem_pwrite(mem_pwrite),
		.mem_paddr(mem_paddr),
		.mem_pwdata(mem_pwdata),
		.mem_prdata(mem_prdata),
		.mem_pready(mem_pready)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_equal(input logic [line_w-1:0] got, input logic [line_w-1:0] exp,
			input string what);
		if (got !== exp) begin
			abort_run($sformatf("[ERROR] %0t: %s: got %0h, expected %0h", $time, what, got, exp));
		end
	endtask

	function automatic logic [addr_w-1:0] make_addr(input logic [tag_w-1:0] tag,
			input logic [index_w-1:0] index, input logic [word_sel_w-1:0] word);
		return {tag, index, word, 2'b00};
	endfunction

	// initial memory contents derived from the byte address
	function automatic logic [word_w-1:0] preload_word(input int unsigned word_index);
		logic [addr_w-1:0] byte_addr;
		byte_addr = addr_w'(word_index << 2);
		return {byte_addr ^ 16'h5ca1, byte_addr};
	endfunction

	function automatic logic [line_w-1:0] ref_line(input logic [line_addr_w-1:0] line_addr);
		return {ref_mem[{line_addr, 2'd3}], ref_mem[{line_addr, 2'd2}],
			ref_mem[{line_addr, 2'd1}], ref_mem[{line_addr, 2'd0}]};
	endfunction

	// one APB transfer with cycles counting the access phase
	task automatic cpu_access(input logic write, input logic [addr_w-1:0] addr,
			input logic [word_w-1:0] data, output logic [word_w-1:0] rdata, output int cycles);
		int waited;
		@(negedge clk);
		psel = 1'b1;	// setup phase
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		cycles = 1;
		waited = 0;
		while (!pready) begin
			if (waited >= access_limit) begin
				abort_run("timeout waiting for pready on a processor access");
			end else begin
				@(negedge clk);
				cycles++;
				waited++;
			end
		end
		rdata = prdata;
		@(negedge clk);	// transfer completed at the rising edge
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic read_check(input logic [addr_w-1:0] addr, input string what,
			output int cycles);
		logic [word_w-1:0] rdata;
		cpu_access(1'b0, addr, '0, rdata, cycles);
		check_equal(rdata, ref_mem[addr[addr_w-1:2]], what);
	endtask

	task automatic write_word(input logic [addr_w-1:0] addr, input logic [word_w-1:0] data,
			output int cycles);
		logic [word_w-1:0] rdata;
		cpu_access(1'b1, addr, data, rdata, cycles);
		ref_mem[addr[addr_w-1:2]] = data;
	endtask

	task automatic after_reset();
		int rd_before;
		int wr_before;
		int cycles;
		check_equal(pready, 1'b0, "pready after reset");
		check_equal(mem_psel, 1'b0, "mem_psel after reset");
		check_equal(mem_penable, 1'b0, "mem_penable after reset");
		rd_before = mem0.rd_count;
		wr_before = mem0.wr_count;
		read_check(make_addr(8'h11, 4'h1, 2'd2), "first read data", cycles);
		check_equal(mem0.rd_count - rd_before, 1, "memory reads on first access");
		check_equal(mem0.wr_count - wr_before, 0, "memory writes on first access");
		check_equal(mem0.last_rd_addr, {8'h11, 4'h1}, "refill line address");
	endtask

	task automatic miss_then_hit();
		logic [addr_w-1:0] addr;
		int rd_before;
		int cycles;
		addr = make_addr(8'h22, 4'h2, 2'd1);
		rd_before = mem0.rd_count;
		read_check(addr, "read miss data", cycles);
		check_equal(mem0.rd_count - rd_before, 1, "memory reads on read miss");
		rd_before = mem0.rd_count;
		read_check(addr, "read hit data", cycles);
		check_equal(cycles, 1, "access cycles on read hit");
		read_check(make_addr(8'h22, 4'h2, 2'd3), "other word of hit line", cycles);
		check_equal(cycles, 1, "access cycles on second hit");
		check_equal(mem0.rd_count - rd_before, 0, "memory reads on read hits");
	endtask

	task automatic write_hit_update();
		logic [addr_w-1:0] addr;
		int rd_before;
		int wr_before;
		int cycles;
		addr = make_addr(8'h33, 4'h3, 2'd0);
		read_check(addr, "line fetch before write", cycles);
		rd_before = mem0.rd_count;
		wr_before = mem0.wr_count;
		write_word(addr, 32'h1234_5678, cycles);
		check_equal(cycles, 1, "access cycles on write hit");
		read_check(addr, "read after write hit", cycles);
		check_equal(mem0.rd_count - rd_before, 0, "memory reads on write hit");
		check_equal(mem0.wr_count - wr_before, 0, "memory writes on write hit");
	endtask

	task automatic lru_replacement();
		logic [addr_w-1:0] addr_a;
		logic [addr_w-1:0] addr_b;
		logic [addr_w-1:0] addr_c;
		int rd_before;
		int cycles;
		addr_a = make_addr(8'h41, 4'h4, 2'd0);
		addr_b = make_addr(8'h42, 4'h4, 2'd1);
		addr_c = make_addr(8'h43, 4'h4, 2'd2);
		read_check(addr_a, "lru read a", cycles);
		read_check(addr_b, "lru read b", cycles);
		read_check(addr_a, "lru read a again", cycles);	// b is now least recent
		rd_before = mem0.rd_count;
		read_check(addr_c, "lru read c", cycles);
		check_equal(mem0.rd_count - rd_before, 1, "memory reads for c");
		check_equal(mem0.last_rd_addr, {8'h43, 4'h4}, "line address for c");
		rd_before = mem0.rd_count;
		read_check(addr_a, "a kept after c", cycles);
		check_equal(mem0.rd_count - rd_before, 0, "memory reads for kept a");
		read_check(addr_b, "b after eviction", cycles);
		check_equal(mem0.rd_count - rd_before, 1, "memory reads for evicted b");
	endtask

	task automatic dirty_eviction();
		logic [addr_w-1:0] addr_x;
		int rd_before;
		int wr_before;
		int cycles;
		addr_x = make_addr(8'h51, 4'h5, 2'd1);
		write_word(addr_x, 32'hdead_beef, cycles);	// write miss allocates a dirty line
		read_check(make_addr(8'h52, 4'h5, 2'd0), "second line of set", cycles);
		rd_before = mem0.rd_count;
		wr_before = mem0.wr_count;
		read_check(make_addr(8'h53, 4'h5, 2'd3), "read that evicts dirty line", cycles);
		check_equal(mem0.wr_count - wr_before, 1, "memory writes on dirty eviction");
		check_equal(mem0.rd_count - rd_before, 1, "memory reads on dirty eviction");
		check_equal(mem0.last_wr_num < mem0.last_rd_num, 1'b1, "write-back before refill");
		check_equal(mem0.last_wr_addr, {8'h51, 4'h5}, "write-back line address");
		check_equal(mem0.last_wr_data, ref_line({8'h51, 4'h5}), "write-back line data");
		read_check(addr_x, "written word after eviction", cycles);
	endtask

	task automatic random_mix();
		logic [addr_w-1:0] addr;
		logic [tag_w-1:0] tag;
		logic [index_w-1:0] index;
		logic [word_sel_w-1:0] word;
		int cycles;
		for (int i = 0; i < 300; i++) begin
			tag = 8'h60 + tag_w'($urandom % 4);	// four tags over two ways
			index = 4'h8 + index_w'($urandom % 4);
			word = word_sel_w'($urandom % 4);
			addr = make_addr(tag, index, word);
			if ($urandom % 2) begin
				write_word(addr, $urandom, cycles);
			end else begin
				read_check(addr, $sformatf("random read %0d", i), cycles);
			end
		end
	endtask

	initial begin
		void'($urandom(32'h6a1));
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		for (int i = 0; i < (1 << (addr_w - 2)); i++) begin
			ref_mem[i] = preload_word(i);
		end
		repeat (5) @(negedge clk);
		reset = 1'b0;
		after_reset();
		miss_then_hit();
		write_hit_update();
		lru_replacement();
		dirty_eviction();
		random_mix();
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/cache_pkg.sv
verilog/cache_way.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
verification/tb_clock.sv
verification/mem_model.sv
verification/cache_tb.sv

// ==== Bender.yml ====
package:
  name: apb_cache

sources:
  - verilog/cache_pkg.sv
  - verilog/cache_way.sv
  - verilog/cache_ctrl.sv
  - verilog/cache_top.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/mem_model.sv
      - verification/cache_tb.sv
